//--- all.f
logic/sdio_proto_pkg.sv
logic/sdio_func_pkg.sv
logic/crc7.sv
logic/sdio_cmd_phy.sv
logic/sdio_cmd52_dispatch.sv
logic/sdio_func_regs.sv
logic/sdio_resp_builder.sv
logic/sdio_cmd_top.sv
sim/sdio_cmd_asserts.sv
sim/sdio_cmd_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module sdio_cmd_tb -f all.f -o sdio_cmd_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sdio_cmd_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit $status
fi
exit 0

//--- sim/sdio_cmd_tb.sv
module sdio_cmd_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import sdio_proto_pkg::*;
  import sdio_func_pkg::*;

  localparam int NUM_FUNCS = 4;
  localparam int REG_DEPTH = 16;
  localparam int FW = $clog2(NUM_FUNCS);
  localparam int AW = $clog2(REG_DEPTH);
  localparam int SEED = 32'h79b54308;
  // Reset sweep 64, directed 8, random mix 64, final sweep 64
  localparam int NUM_CMDS = 200;
  localparam int CYCLES_PER_CMD = 120;
  localparam int TIMEOUT_CYCLES = NUM_CMDS * CYCLES_PER_CMD;
  localparam int RSP_WAIT = 16;

  typedef logic [CMD_FRAME_BITS-1:0] frame_t;

  logic      sdio_clk;
  logic      rst;
  logic      sdio_cmd_in;
  logic      sdio_cmd_out;
  logic      sdio_cmd_dir;
  reg_byte_t model_mem [NUM_FUNCS][REG_DEPTH];
  int        cycle_cnt;

  sdio_cmd_top #(
    .NUM_FUNCS (NUM_FUNCS),
    .REG_DEPTH (REG_DEPTH)
  ) dut_i (
    .sdio_clk     (sdio_clk),
    .rst          (rst),
    .sdio_cmd_in  (sdio_cmd_in),
    .sdio_cmd_out (sdio_cmd_out),
    .sdio_cmd_dir (sdio_cmd_dir)
  );

  initial begin
    sdio_clk = 1'b0;
    forever #4 sdio_clk = ~sdio_clk;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge sdio_clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Regression failed");
    $fatal(1);
  end

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_payload(input string name, input rsp_payload_t got,
                               input rsp_payload_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_crc(input string name, input logic [6:0] got, input logic [6:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_byte(input string name, input reg_byte_t got, input reg_byte_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Serial CRC7, x^7 + x^3 + 1, MSB first from zero
  function automatic logic [6:0] crc7_calc(input logic [CRC_DATA_BITS-1:0] bits);
    logic [6:0] c;
    logic       fb;
    c = '0;
    for (int i = CRC_DATA_BITS - 1; i >= 0; i--) begin
      fb = bits[i] ^ c[6];
      c = {c[5:0], 1'b0};
      if (fb) begin
        c = c ^ 7'h09;
      end
    end
    return c;
  endfunction

  function automatic cmd_arg_t make_arg(input logic rw, input func_num_t func, input logic raw,
                                        input reg_addr_t addr, input reg_byte_t wdata);
    cmd_arg_t arg;
    arg = '0;
    arg[ARG_RW_BIT] = rw;
    arg[ARG_FUNC_MSB:ARG_FUNC_LSB] = func;
    arg[ARG_RAW_BIT] = raw;
    arg[ARG_ADDR_MSB:ARG_ADDR_LSB] = addr;
    arg[ARG_WDATA_MSB:ARG_WDATA_LSB] = wdata;
    return arg;
  endfunction

  // Host frame with direction bit 1
  // A nonzero crc_flip corrupts the CRC
  function automatic frame_t build_frame(input cmd_index_t idx, input cmd_arg_t arg,
                                         input logic [6:0] crc_flip);
    logic [CRC_DATA_BITS-1:0] head;
    head = {1'b0, 1'b1, idx, arg};
    return {head, crc7_calc(head) ^ crc_flip, 1'b1};
  endfunction

  task automatic send_frame(input frame_t frame);
    for (int i = CMD_FRAME_BITS - 1; i >= 0; i--) begin
      @(negedge sdio_clk);
      sdio_cmd_in = frame[i];
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge sdio_clk);
      sdio_cmd_in = 1'b1;
    end
  endtask

  task automatic capture_response(output frame_t frame);
    int waited;
    waited = 0;
    do begin
      @(negedge sdio_clk);
      waited++;
    end while (!sdio_cmd_dir && waited < RSP_WAIT);
    if (!sdio_cmd_dir) begin
      $display("No response from the DUT within %0d cycles at %0t", RSP_WAIT, $time);
      abort_run();
    end
    frame[CMD_FRAME_BITS-1] = sdio_cmd_out;
    for (int i = CMD_FRAME_BITS - 2; i >= 0; i--) begin
      @(negedge sdio_clk);
      frame[i] = sdio_cmd_out;
    end
  endtask

  task automatic expect_silence();
    repeat (RSP_WAIT) begin
      @(negedge sdio_clk);
      if (sdio_cmd_dir) begin
        $display("Unexpected response on the CMD line at %0t", $time);
        abort_run();
      end
    end
  endtask

  // Send one CMD52, predict the R5 answer and update the model
  task automatic run_cmd52(input logic rw, input func_num_t func, input logic raw,
                           input reg_addr_t addr, input reg_byte_t wdata,
                           output reg_byte_t got_data);
    rsp_payload_t  exp;
    rsp_payload_t  got;
    frame_t        frame;
    logic [FW-1:0] f;
    logic [AW-1:0] a;
    exp.index = CMD52_INDEX;
    exp.stuff = '0;
    exp.flags = '0;
    exp.data  = '0;
    f = func[FW-1:0];
    a = addr[AW-1:0];
    exp.flags[R5_FLAG_FUNC_NUM]     = (int'(func) >= NUM_FUNCS);
    exp.flags[R5_FLAG_OUT_OF_RANGE] = (int'(addr) >= REG_DEPTH);
    if (exp.flags == 8'h00) begin
      if (rw) begin
        exp.data = raw ? wdata : model_mem[f][a];
        model_mem[f][a] = wdata;
      end else begin
        exp.data = model_mem[f][a];
      end
    end
    send_frame(build_frame(CMD52_INDEX, make_arg(rw, func, raw, addr, wdata), 7'h00));
    capture_response(frame);
    check_bit("rsp start bit", frame[47], 1'b0);
    check_bit("rsp direction bit", frame[46], 1'b0);
    check_bit("rsp end bit", frame[0], 1'b1);
    got = rsp_payload_t'(frame[45:8]);
    check_payload("rsp_payload", got, exp);
    check_crc("rsp_crc", frame[7:1], crc7_calc(frame[47:8]));
    got_data = got.data;
    idle_cycles(1 + int'($urandom_range(2, 0)));
  endtask

  task automatic send_bad_crc(input cmd_arg_t arg);
    logic [6:0] flip;
    flip = 7'($urandom_range(127, 1));
    send_frame(build_frame(CMD52_INDEX, arg, flip));
    expect_silence();
  endtask

  task automatic send_other_index(input cmd_arg_t arg);
    cmd_index_t idx;
    do begin
      idx = cmd_index_t'($urandom_range(63, 0));
    end while (idx == CMD52_INDEX);
    send_frame(build_frame(idx, arg, 7'h00));
    expect_silence();
  endtask

  task automatic sweep_all();
    reg_byte_t d;
    for (int f = 0; f < NUM_FUNCS; f++) begin
      for (int a = 0; a < REG_DEPTH; a++) begin
        run_cmd52(1'b0, func_num_t'(f), 1'b0, reg_addr_t'(a), 8'h00, d);
      end
    end
  endtask

  initial begin
    reg_byte_t d;
    int        kind;
    logic      rw;
    logic      raw;
    func_num_t func;
    reg_addr_t addr;
    reg_byte_t wdata;
    rst = 1'b1;
    sdio_cmd_in = 1'b1;
    void'($urandom(SEED));
    for (int f = 0; f < NUM_FUNCS; f++) begin
      for (int a = 0; a < REG_DEPTH; a++) begin
        model_mem[f][a] = 8'h00;
      end
    end
    repeat (4) @(negedge sdio_clk);
    rst = 1'b0;

    // Every byte reads zero after reset
    sweep_all();

    // Function 5 and address 0x13 both alias function 1, byte 3
    run_cmd52(1'b1, 3'd1, 1'b1, 17'd3, 8'ha5, d);
    check_byte("raw write data", d, 8'ha5);
    run_cmd52(1'b1, 3'd5, 1'b0, 17'd3, 8'h3c, d);
    run_cmd52(1'b0, 3'd1, 1'b0, 17'd3, 8'h00, d);
    check_byte("reg after bad function", d, 8'ha5);
    run_cmd52(1'b1, 3'd1, 1'b0, 17'h13, 8'h77, d);
    send_bad_crc(make_arg(1'b1, 3'd1, 1'b0, 17'd3, 8'h5a));
    send_other_index(make_arg(1'b1, 3'd1, 1'b0, 17'd3, 8'h66));
    run_cmd52(1'b0, 3'd1, 1'b0, 17'd3, 8'h00, d);
    check_byte("reg after dropped commands", d, 8'ha5);
    run_cmd52(1'b1, 3'd2, 1'b0, 17'd15, 8'hc3, d);
    check_byte("old value on plain write", d, 8'h00);

    for (int i = 0; i < 64; i++) begin
      kind  = int'($urandom_range(9, 0));
      rw    = ($urandom_range(1, 0) != 0);
      raw   = ($urandom_range(1, 0) != 0);
      func  = func_num_t'($urandom_range(NUM_FUNCS - 1, 0));
      addr  = reg_addr_t'($urandom_range(REG_DEPTH - 1, 0));
      wdata = reg_byte_t'($urandom_range(255, 0));
      case (kind)
        0: begin
          func = func_num_t'($urandom_range(7, NUM_FUNCS));
          run_cmd52(rw, func, raw, addr, wdata, d);
        end
        1: begin
          addr = reg_addr_t'($urandom_range(131071, REG_DEPTH));
          run_cmd52(rw, func, raw, addr, wdata, d);
        end
        2: send_bad_crc(make_arg(rw, func, raw, addr, wdata));
        3: send_other_index(make_arg(rw, func, raw, addr, wdata));
        default: run_cmd52(rw, func, raw, addr, wdata, d);
      endcase
    end

    sweep_all();
    $display("Regression passed");
    $finish;
  end

endmodule

//--- sim/sdio_cmd_asserts.sv
module sdio_cmd_asserts (
  input logic sdio_clk,
  input logic rst,
  input logic sdio_cmd_dir,
  input logic sdio_cmd_out
);
  timeunit 1ns;
  timeprecision 1ps;

  import sdio_proto_pkg::*;

  // Consecutive cycles with the device driving the line
  logic [5:0] high_cnt;

  always_ff @(posedge sdio_clk) begin
    if (rst) begin
      high_cnt <= '0;
    end else if (sdio_cmd_dir) begin
      high_cnt <= high_cnt + 6'd1;
    end else begin
      high_cnt <= '0;
    end
  end

  a_dir_low_in_reset: assert property (@(posedge sdio_clk) $past(rst) |-> !sdio_cmd_dir)
    else $error("sdio_cmd_dir high during reset");

  a_dir_not_too_long: assert property (@(posedge sdio_clk) disable iff (rst)
    sdio_cmd_dir |-> high_cnt < 6'(CMD_FRAME_BITS))
    else $error("sdio_cmd_dir high longer than one frame");

  a_dir_frame_len: assert property (@(posedge sdio_clk) disable iff (rst)
    $fell(sdio_cmd_dir) |-> high_cnt == 6'(CMD_FRAME_BITS))
    else $error("sdio_cmd_dir high period is not one frame");

  a_line_idle_high: assert property (@(posedge sdio_clk) disable iff (rst)
    $fell(sdio_cmd_dir) |-> sdio_cmd_out)
    else $error("sdio_cmd_out not high after the response");

endmodule

bind sdio_cmd_phy sdio_cmd_asserts asserts_i (
  .sdio_clk     (sdio_clk),
  .rst          (rst),
  .sdio_cmd_dir (sdio_cmd_dir),
  .sdio_cmd_out (sdio_cmd_out)
);

//--- logic/sdio_cmd_top.sv
module sdio_cmd_top #(
  parameter int NUM_FUNCS = 4,
  parameter int REG_DEPTH = 16
) (
  input  logic sdio_clk,
  input  logic rst,
  input  logic sdio_cmd_in,
  output logic sdio_cmd_out,
  output logic sdio_cmd_dir
);

  import sdio_proto_pkg::*;
  import sdio_func_pkg::*;

  logic                        cmd_stb;
  cmd_index_t                  cmd;
  cmd_arg_t                    cmd_arg;
  logic [NUM_FUNCS-1:0]        req_sel;
  reg_addr_t                   req_addr;
  logic                        req_we;
  logic                        req_raw;
  reg_byte_t                   req_wdata;
  logic                        req_stb;
  logic [7:0]                  req_flags;
  logic [NUM_FUNCS-1:0]        rd_valid;
  reg_byte_t [NUM_FUNCS-1:0]   rd_data;
  logic                        rsp_valid;
  rsp_payload_t                rsp_payload;

  sdio_cmd_phy phy_i (
    .sdio_clk     (sdio_clk),
    .rst          (rst),
    .sdio_cmd_in  (sdio_cmd_in),
    .sdio_cmd_out (sdio_cmd_out),
    .sdio_cmd_dir (sdio_cmd_dir),
    .cmd_stb      (cmd_stb),
    .cmd          (cmd),
    .cmd_arg      (cmd_arg),
    .rsp_valid    (rsp_valid),
    .rsp_payload  (rsp_payload)
  );

  sdio_cmd52_dispatch #(
    .NUM_FUNCS (NUM_FUNCS),
    .REG_DEPTH (REG_DEPTH)
  ) dispatch_i (
    .sdio_clk  (sdio_clk),
    .rst       (rst),
    .cmd_stb   (cmd_stb),
    .cmd       (cmd),
    .cmd_arg   (cmd_arg),
    .req_sel   (req_sel),
    .req_addr  (req_addr),
    .req_we    (req_we),
    .req_raw   (req_raw),
    .req_wdata (req_wdata),
    .req_stb   (req_stb),
    .req_flags (req_flags)
  );

  // One register bank per function
  for (genvar i = 0; i < NUM_FUNCS; i++) begin : g_func
    sdio_func_regs #(
      .REG_DEPTH (REG_DEPTH)
    ) regs_i (
      .sdio_clk (sdio_clk),
      .rst      (rst),
      .sel      (req_sel[i]),
      .we       (req_we),
      .raw      (req_raw),
      .addr     (req_addr),
      .wdata    (req_wdata),
      .rd_valid (rd_valid[i]),
      .rd_data  (rd_data[i])
    );
  end

  sdio_resp_builder #(
    .NUM_FUNCS (NUM_FUNCS)
  ) builder_i (
    .sdio_clk    (sdio_clk),
    .rst         (rst),
    .req_stb     (req_stb),
    .req_flags   (req_flags),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .rsp_valid   (rsp_valid),
    .rsp_payload (rsp_payload)
  );

endmodule

//--- logic/sdio_resp_builder.sv
module sdio_resp_builder #(
  parameter int NUM_FUNCS = 4
) (
  input  logic                                     sdio_clk,
  input  logic                                     rst,
  input  logic                                     req_stb,
  input  logic [7:0]                               req_flags,
  input  logic [NUM_FUNCS-1:0]                     rd_valid,
  input  sdio_func_pkg::reg_byte_t [NUM_FUNCS-1:0] rd_data,
  output logic                                     rsp_valid,
  output sdio_proto_pkg::rsp_payload_t             rsp_payload
);

  import sdio_proto_pkg::*;
  import sdio_func_pkg::*;

  logic       pending;
  logic [7:0] pend_flags;
  logic       finish;
  reg_byte_t  rd_byte;

  // At most one bank answers
  always_comb begin
    rd_byte = '0;
    for (int i = 0; i < NUM_FUNCS; i++) begin
      if (rd_valid[i]) begin
        rd_byte = rd_data[i];
      end
    end
  end

  // Flagged requests close in the slot where bank data would arrive
  assign finish = pending && ((|rd_valid) || (pend_flags != '0));

  always_ff @(posedge sdio_clk) begin
    if (rst) begin
      pending   <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= finish;
      if (req_stb) begin
        pending <= 1'b1;
      end else if (finish) begin
        pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge sdio_clk) begin
    if (req_stb) begin
      pend_flags <= req_flags;
    end
    if (finish) begin
      rsp_payload.index <= CMD52_INDEX;
      rsp_payload.stuff <= '0;
      rsp_payload.flags <= pend_flags;
      rsp_payload.data  <= (pend_flags != '0) ? '0 : rd_byte;
    end
  end

endmodule

//--- logic/sdio_func_regs.sv
module sdio_func_regs #(
  parameter int REG_DEPTH = 16
) (
  input  logic                     sdio_clk,
  input  logic                     rst,
  input  logic                     sel,
  input  logic                     we,
  input  logic                     raw,
  input  sdio_func_pkg::reg_addr_t addr,
  input  sdio_func_pkg::reg_byte_t wdata,
  output logic                     rd_valid,
  output sdio_func_pkg::reg_byte_t rd_data
);

  import sdio_func_pkg::*;

  localparam int AW = (REG_DEPTH > 1) ? $clog2(REG_DEPTH) : 1;

  reg_byte_t       mem [REG_DEPTH];
  logic [AW-1:0]   idx;

  // Dispatcher has already range-checked the address
  assign idx = addr[AW-1:0];

  always_ff @(posedge sdio_clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
      for (int i = 0; i < REG_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else begin
      rd_valid <= sel;
      if (sel && we) begin
        mem[idx] <= wdata;
      end
    end
  end

  // Read after write only with RAW set
  always_ff @(posedge sdio_clk) begin
    if (sel) begin
      rd_data <= (we && raw) ? wdata : mem[idx];
    end
  end

endmodule

//--- logic/sdio_cmd52_dispatch.sv
module sdio_cmd52_dispatch #(
  parameter int NUM_FUNCS = 4,
  parameter int REG_DEPTH = 16
) (
  input  logic                       sdio_clk,
  input  logic                       rst,
  input  logic                       cmd_stb,
  input  sdio_proto_pkg::cmd_index_t cmd,
  input  sdio_proto_pkg::cmd_arg_t   cmd_arg,
  output logic [NUM_FUNCS-1:0]       req_sel,
  output sdio_func_pkg::reg_addr_t   req_addr,
  output logic                       req_we,
  output logic                       req_raw,
  output sdio_func_pkg::reg_byte_t   req_wdata,
  output logic                       req_stb,
  output logic [7:0]                 req_flags
);

  import sdio_proto_pkg::*;
  import sdio_func_pkg::*;

  func_num_t  func;
  reg_addr_t  addr;
  logic [7:0] flags;
  logic       is_cmd52;

  assign func     = cmd_arg[ARG_FUNC_MSB:ARG_FUNC_LSB];
  assign addr     = cmd_arg[ARG_ADDR_MSB:ARG_ADDR_LSB];
  assign is_cmd52 = cmd_stb && (cmd == CMD52_INDEX);

  always_comb begin
    flags = '0;
    flags[R5_FLAG_FUNC_NUM]     = (int'(func) >= NUM_FUNCS);
    flags[R5_FLAG_OUT_OF_RANGE] = (int'(addr) >= REG_DEPTH);
  end

  always_ff @(posedge sdio_clk) begin
    if (rst) begin
      req_sel <= '0;
      req_stb <= 1'b0;
    end else begin
      req_stb <= is_cmd52;
      // A flagged request touches no bank
      for (int i = 0; i < NUM_FUNCS; i++) begin
        req_sel[i] <= is_cmd52 && (flags == '0) && (int'(func) == i);
      end
    end
  end

  always_ff @(posedge sdio_clk) begin
    if (cmd_stb) begin
      req_addr  <= addr;
      req_we    <= cmd_arg[ARG_RW_BIT];
      req_raw   <= cmd_arg[ARG_RAW_BIT];
      req_wdata <= cmd_arg[ARG_WDATA_MSB:ARG_WDATA_LSB];
      req_flags <= flags;
    end
  end

endmodule

//--- logic/sdio_cmd_phy.sv
module sdio_cmd_phy (
  input  logic                         sdio_clk,
  input  logic                         rst,
  input  logic                         sdio_cmd_in,
  output logic                         sdio_cmd_out,
  output logic                         sdio_cmd_dir,
  output logic                         cmd_stb,
  output sdio_proto_pkg::cmd_index_t   cmd,
  output sdio_proto_pkg::cmd_arg_t     cmd_arg,
  input  logic                         rsp_valid,
  input  sdio_proto_pkg::rsp_payload_t rsp_payload
);

  import sdio_proto_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_RX, ST_TX} state_t;

  // Index, argument and received CRC behind the direction bit
  localparam int RX_BITS = CMD_FRAME_BITS - 3;
  // Transmitted bits after the start bit that still feed the CRC
  localparam int TX_BITS = CRC_DATA_BITS - 1;
  localparam int ARG_BITS = $bits(cmd_arg_t);

  localparam logic [5:0] CNT_CRC_START = 6'(CRC_DATA_BITS);
  localparam logic [5:0] CNT_END       = 6'(CMD_FRAME_BITS - 1);
  localparam logic [5:0] CNT_DONE      = 6'(CMD_FRAME_BITS);

  state_t              state;
  logic [5:0]          bit_cnt;
  logic [RX_BITS-1:0]  rx_sh;
  logic [TX_BITS-1:0]  tx_sh;
  logic                crc_clear;
  logic                crc_en;
  logic                crc_shift;
  logic                crc_bit;
  logic [CRC_BITS-1:0] crc;

  crc7 crc_i (
    .sdio_clk  (sdio_clk),
    .rst       (rst),
    .clear     (crc_clear),
    .en        (crc_en),
    .shift_out (crc_shift),
    .data_bit  (crc_bit),
    .crc       (crc)
  );

  // CRC source follows the bit that goes on or comes off the line
  always_comb begin
    crc_clear = 1'b0;
    crc_en    = 1'b0;
    crc_shift = 1'b0;
    crc_bit   = 1'b0;
    case (state)
      ST_IDLE: begin
        // Start bit is 0 either way
        if (rsp_valid || !sdio_cmd_in) begin
          crc_en = 1'b1;
        end else begin
          crc_clear = 1'b1;
        end
      end
      ST_RX: begin
        crc_en    = (bit_cnt < CNT_CRC_START);
        crc_clear = (bit_cnt == CNT_END);
        crc_bit   = sdio_cmd_in;
      end
      ST_TX: begin
        crc_en    = (bit_cnt < CNT_CRC_START);
        crc_shift = (bit_cnt >= CNT_CRC_START) && (bit_cnt < CNT_END);
        crc_bit   = tx_sh[TX_BITS-1];
      end
      default: crc_clear = 1'b1;
    endcase
  end

  always_ff @(posedge sdio_clk) begin
    if (rst) begin
      state        <= ST_IDLE;
      bit_cnt      <= '0;
      sdio_cmd_out <= 1'b1;
      sdio_cmd_dir <= 1'b0;
      cmd_stb      <= 1'b0;
    end else begin
      cmd_stb <= 1'b0;
      case (state)
        ST_IDLE: begin
          bit_cnt <= 6'd1;
          if (rsp_valid) begin
            // Drive the start bit right away
            state        <= ST_TX;
            sdio_cmd_dir <= 1'b1;
            sdio_cmd_out <= 1'b0;
          end else if (!sdio_cmd_in) begin
            state <= ST_RX;
          end
        end
        ST_RX: begin
          bit_cnt <= bit_cnt + 6'd1;
          if (bit_cnt == CNT_END) begin
            // Bad CRC drops the command without a trace
            state   <= ST_IDLE;
            cmd_stb <= (rx_sh[CRC_BITS-1:0] == crc);
          end
        end
        ST_TX: begin
          bit_cnt <= bit_cnt + 6'd1;
          if (bit_cnt < CNT_CRC_START) begin
            sdio_cmd_out <= tx_sh[TX_BITS-1];
          end else if (bit_cnt < CNT_END) begin
            sdio_cmd_out <= crc[CRC_BITS-1];
          end else begin
            sdio_cmd_out <= 1'b1;
            if (bit_cnt == CNT_DONE) begin
              sdio_cmd_dir <= 1'b0;
              state        <= ST_IDLE;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Shift registers and command fields
  always_ff @(posedge sdio_clk) begin
    if (state == ST_RX && bit_cnt < CNT_END) begin
      rx_sh <= {rx_sh[RX_BITS-2:0], sdio_cmd_in};
    end
    if (state == ST_RX && bit_cnt == CNT_END) begin
      cmd     <= rx_sh[CRC_BITS+ARG_BITS +: $bits(cmd_index_t)];
      cmd_arg <= rx_sh[CRC_BITS +: ARG_BITS];
    end
    if (state == ST_IDLE && rsp_valid) begin
      // Direction bit 0 leads the payload
      tx_sh <= {1'b0, rsp_payload};
    end else if (state == ST_TX) begin
      tx_sh <= {tx_sh[TX_BITS-2:0], 1'b0};
    end
  end

endmodule

//--- logic/crc7.sv
module crc7 (
  input  logic       sdio_clk,
  input  logic       rst,
  input  logic       clear,
  input  logic       en,
  input  logic       shift_out,
  input  logic       data_bit,
  output logic [6:0] crc
);

  logic fb;

  // x^7 + x^3 + 1
  assign fb = data_bit ^ crc[6];

  always_ff @(posedge sdio_clk) begin
    if (rst || clear) begin
      crc <= '0;
    end else if (shift_out) begin
      // MSB goes out on the line, zeros fill behind
      crc <= {crc[5:0], 1'b0};
    end else if (en) begin
      crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
    end
  end

endmodule

//--- logic/sdio_func_pkg.sv
package sdio_func_pkg;

  // Function number as carried in the CMD52 argument
  typedef logic [2:0] func_num_t;

  // Register address within one function
  typedef logic [16:0] reg_addr_t;

  // One register byte, written or read by CMD52
  typedef logic [7:0] reg_byte_t;

endpackage

//--- logic/sdio_proto_pkg.sv
package sdio_proto_pkg;

  typedef logic [5:0]  cmd_index_t;
  typedef logic [31:0] cmd_arg_t;

  // Command and response frames share one length
  localparam int CMD_FRAME_BITS = 48;
  localparam int CRC_BITS       = 7;
  // Start, direction, index and argument are covered by the CRC
  localparam int CRC_DATA_BITS  = CMD_FRAME_BITS - CRC_BITS - 1;

  localparam cmd_index_t CMD52_INDEX = 6'd52;

  // CMD52 argument fields
  localparam int ARG_RW_BIT     = 31;
  localparam int ARG_FUNC_MSB   = 30;
  localparam int ARG_FUNC_LSB   = 28;
  localparam int ARG_RAW_BIT    = 27;
  localparam int ARG_ADDR_MSB   = 25;
  localparam int ARG_ADDR_LSB   = 9;
  localparam int ARG_WDATA_MSB  = 7;
  localparam int ARG_WDATA_LSB  = 0;

  // R5 response flag bits
  localparam int R5_FLAG_OUT_OF_RANGE = 0;
  localparam int R5_FLAG_FUNC_NUM     = 1;

  // Index then R5 argument, as sent after the start and direction bits
  typedef struct packed {
    cmd_index_t  index;
    logic [15:0] stuff;
    logic [7:0]  flags;
    logic [7:0]  data;
  } rsp_payload_t;

endpackage
